// File: verilog/logger_params.svh
// constants shared by the UART-to-SD logger RTL and its testbench
// include wherever sizes, timing or register addresses are needed
`ifndef LOGGER_PARAMS_SVH
`define LOGGER_PARAMS_SVH

// sector and FIFO sizing
`define LOG_SECTOR_BYTES 512
`define LOG_FIFO_DEPTH 1024
`define LOG_FIFO_AW 10

// serial line, clocks per bit
`define LOG_CLKS_PER_BIT 8

// file update policy
`define LOG_SECTORS_PER_UPDATE 2
`define LOG_MAX_SECTORS 12

// wishbone word addresses
`define LOG_REG_CTRL 3'd0
`define LOG_REG_FILESEC 3'd1
`define LOG_REG_DIRSEC 3'd2
`define LOG_REG_FATSEC 3'd3
`define LOG_REG_CLUSTER 3'd4
`define LOG_REG_SPC 3'd5
`define LOG_REG_STATUS 3'd6

`endif

// File: verilog/loggerPkg.sv
// types shared between the logger blocks and the testbench
// config, status, sector request and the FAT directory entry
`default_nettype none

package loggerPkg;

  // configuration held by the register block
  typedef struct packed {
    logic        enable;
    logic [31:0] fileSector;
    logic [31:0] dirSector;
    logic [31:0] fatSector;
    logic [27:0] startCluster;
    logic [3:0]  dirSlot;
    logic [7:0]  sectorsPerCluster;
  } logCfgT;

  // progress reported back through STATUS
  typedef struct packed {
    logic [15:0] sectorsWritten;
    logic        overLimit;
  } logStatusT;

  typedef enum logic [1:0] {SEC_DATA, SEC_DIR, SEC_FAT} secKindE;

  // request towards the card side
  typedef struct packed {
    logic        start;
    secKindE     kind;
    logic [31:0] sectorAddr;
  } secReqT;

  // ---------------------------------------------------------------------
  // 32-byte short directory entry, byte 0 is the first name character
  // multi-byte fields hold little-endian byte order as stored on disk
  // ---------------------------------------------------------------------
  typedef struct packed {
    logic [0:10][7:0] name;
    logic [7:0]       attr;
    // nt flags, create time/date, access date
    logic [0:7][7:0]  reserved;
    logic [15:0]      clusterHi;
    logic [31:0]      timeDate;
    logic [15:0]      clusterLo;
    logic [31:0]      fileSize;
  } dirFieldsT;

  typedef union packed {
    logic [0:31][7:0] raw;
    dirFieldsT        f;
  } dirEntryU;

endpackage

`default_nettype wire

// File: verilog/uartRx.sv
// 8N1 UART receiver, one rxValid strobe per good frame
// frames with a low stop bit are dropped
`timescale 1ns/100ps
`default_nettype none
`include "logger_params.svh"

module uartRx (
  input  wire logic clk,
  input  wire logic rstn,
  input  wire logic rx,
  output byte       rxByte,
  output logic      rxValid
);

  localparam int CntW = $clog2(`LOG_CLKS_PER_BIT);
  localparam logic [CntW-1:0] BitLast = CntW'(`LOG_CLKS_PER_BIT - 1);
  localparam logic [CntW-1:0] HalfLast = CntW'(`LOG_CLKS_PER_BIT / 2 - 1);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rxStateE;

  rxStateE         state;
  // two sync stages plus one history flop for edge detect
  logic [2:0]      rxSync;
  logic [CntW-1:0] cnt;
  logic [2:0]      bitIdx;
  logic [7:0]      shiftReg;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rxSync  <= 3'b111;
      state   <= RX_IDLE;
      cnt     <= '0;
      bitIdx  <= '0;
      rxValid <= 1'b0;
    end else begin
      rxSync  <= {rxSync[1:0], rx};
      rxValid <= 1'b0;
      case (state)
        RX_IDLE: begin
          // falling edge on the synced line
          if (rxSync[2] && !rxSync[1]) begin
            state <= RX_START;
            cnt   <= '0;
          end
        end
        RX_START: begin
          cnt <= cnt + 1'b1;
          // recheck at the middle of the start bit, glitch filter
          if (cnt == HalfLast) begin
            cnt    <= '0;
            bitIdx <= '0;
            state  <= rxSync[1] ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          cnt <= cnt + 1'b1;
          if (cnt == BitLast) begin
            cnt    <= '0;
            bitIdx <= bitIdx + 1'b1;
            if (bitIdx == 3'd7) state <= RX_STOP;
          end
        end
        default: begin
          cnt <= cnt + 1'b1;
          // middle of stop bit, valid only when high
          if (cnt == BitLast) begin
            rxValid <= rxSync[1];
            state   <= RX_IDLE;
          end
        end
      endcase
    end
  end

  // lsb first, shift in from the top
  always_ff @(posedge clk) begin
    if (state == RX_DATA && cnt == BitLast) shiftReg <= {rxSync[1], shiftReg[7:1]};
    if (state == RX_STOP && cnt == BitLast) rxByte <= shiftReg;
  end

endmodule

`default_nettype wire

// File: verilog/byteFifo.sv
// synchronous byte FIFO with fill count and a head shown without latency
// push while full and pop while empty are ignored
`timescale 1ns/100ps
`default_nettype none
`include "logger_params.svh"

module byteFifo (
  input  wire logic                  clk,
  input  wire logic                  rstn,
  input  wire logic                  push,
  input  wire logic [7:0]            pushByte,
  input  wire logic                  pop,
  output logic      [7:0]            popByte,
  output logic      [`LOG_FIFO_AW:0] count,
  output logic                       full
);

  // byte storage
  logic [7:0] mem [`LOG_FIFO_DEPTH];

  logic [`LOG_FIFO_AW-1:0] wrPtr;
  logic [`LOG_FIFO_AW-1:0] rdPtr;
  logic                    doPush;
  logic                    doPop;

  assign full   = (count == (`LOG_FIFO_AW+1)'(`LOG_FIFO_DEPTH));
  assign doPush = push && !full;
  assign doPop  = pop && (count != '0);

  always_ff @(posedge clk) begin
    if (doPush) mem[wrPtr] <= pushByte;
  end

  // pointers wrap naturally since the depth is a power of two
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) wrPtr <= wrPtr + 1'b1;
      if (doPop) rdPtr <= rdPtr + 1'b1;
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // first-word-fall-through head
  assign popByte = mem[rdPtr];

endmodule

`default_nettype wire

// File: verilog/loggerRegs.sv
// wishbone classic register block, config words plus read-only status
// zero wait states, ack one cycle after cyc and stb
`timescale 1ns/100ps
`default_nettype none
`include "logger_params.svh"

module loggerRegs (
  input  wire logic                  clk,
  input  wire logic                  rstn,
  input  wire logic                  cyc,
  input  wire logic                  stb,
  input  wire logic                  we,
  input  wire logic [2:0]            adr,
  input  wire logic [31:0]           datW,
  output logic      [31:0]           datR,
  output logic                       ack,
  output loggerPkg::logCfgT          cfg,
  input  wire loggerPkg::logStatusT  status
);

  logic        req;
  logic [31:0] rdWord;

  // new request only when no ack is pending
  assign req = cyc && stb && !ack;

  // ---------------------------------------------------------------------
  // read mux
  // ---------------------------------------------------------------------
  always_comb begin
    case (adr)
      `LOG_REG_CTRL:    rdWord = {31'd0, cfg.enable};
      `LOG_REG_FILESEC: rdWord = cfg.fileSector;
      `LOG_REG_DIRSEC:  rdWord = cfg.dirSector;
      `LOG_REG_FATSEC:  rdWord = cfg.fatSector;
      // slot in the top nibble, cluster below
      `LOG_REG_CLUSTER: rdWord = {cfg.dirSlot, cfg.startCluster};
      `LOG_REG_SPC:     rdWord = {24'd0, cfg.sectorsPerCluster};
      `LOG_REG_STATUS:  rdWord = {15'd0, status};
      default:          rdWord = 32'd0;
    endcase
  end

  // ---------------------------------------------------------------------
  // write side and ack
  // ---------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ack  <= 1'b0;
      datR <= '0;
      cfg  <= '0;
    end else begin
      ack <= req;
      if (req) begin
        datR <= rdWord;
        if (we) begin
          // status writes fall through to default
          case (adr)
            `LOG_REG_CTRL:    cfg.enable <= datW[0];
            `LOG_REG_FILESEC: cfg.fileSector <= datW;
            `LOG_REG_DIRSEC:  cfg.dirSector <= datW;
            `LOG_REG_FATSEC:  cfg.fatSector <= datW;
            `LOG_REG_CLUSTER: begin
              cfg.dirSlot      <= datW[31:28];
              cfg.startCluster <= datW[27:0];
            end
            `LOG_REG_SPC:     cfg.sectorsPerCluster <= datW[7:0];
            default: ;
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/sectorSequencer.sv
// sector write sequencer, data sectors from the FIFO then directory/FAT
// rewrites as the file grows; stops at the sector limit
`timescale 1ns/100ps
`default_nettype none
`include "logger_params.svh"

module sectorSequencer (
  input  wire logic                    clk,
  input  wire logic                    rstn,
  input  wire loggerPkg::logCfgT       cfg,
  output loggerPkg::logStatusT         status,
  input  wire logic [7:0]              fifoByte,
  input  wire logic [`LOG_FIFO_AW:0]   fifoCount,
  output logic                         fifoPop,
  output loggerPkg::secReqT            secReq,
  output logic      [7:0]              secByte,
  input  wire logic                    cardReady,
  input  wire logic                    byteTake,
  input  wire logic                    secDone
);

  import loggerPkg::*;

  localparam int IdxW = $clog2(`LOG_SECTOR_BYTES);

  typedef enum logic [2:0] {S_IDLE, S_REQ, S_DATA, S_DIR, S_FAT, S_STOP} seqStateE;

  seqStateE        state;
  secKindE         reqKind;
  logic [31:0]     reqAddr;
  logic [15:0]     sectorCount;
  logic [15:0]     usedClusters;
  logic            overLimit;
  logic            dirPending;
  logic            fatPending;
  // byte position inside the current sector
  logic [IdxW-1:0] byteIdx;

  logic [15:0]     nextCount;
  logic            dirDue;
  logic            fatDue;
  logic            dataReady;
  logic [27:0]     lastCluster;
  logic [IdxW-3:0] fatEntry;
  logic [31:0]     fatWord;
  dirEntryU        dirEntry;

  function automatic logic [15:0] swap16(input logic [15:0] v);
    return {v[7:0], v[15:8]};
  endfunction

  function automatic logic [31:0] swap32(input logic [31:0] v);
    return {v[7:0], v[15:8], v[23:16], v[31:24]};
  endfunction

  // ---------------------------------------------------------------------
  // update decisions, evaluated when a data sector completes
  // ---------------------------------------------------------------------
  assign nextCount = sectorCount + 16'd1;
  assign dirDue    = (nextCount % `LOG_SECTORS_PER_UPDATE) == 0;
  // spc is a power of two, so a mask gives the modulo
  assign fatDue    = (nextCount[7:0] & (cfg.sectorsPerCluster - 8'd1)) == 8'd0;
  assign dataReady = cfg.enable && (fifoCount >= `LOG_SECTOR_BYTES);

  // directory entry, built by field and streamed out as raw bytes
  always_comb begin
    dirEntry             = '0;
    dirEntry.f.name      = "LOG     DAT";
    // archive
    dirEntry.f.attr      = 8'h20;
    dirEntry.f.clusterHi = swap16({4'd0, cfg.startCluster[27:16]});
    dirEntry.f.clusterLo = swap16(cfg.startCluster[15:0]);
    dirEntry.f.fileSize  = swap32({7'd0, sectorCount, 9'd0});
  end

  // FAT chain, entry index is the cluster number
  assign lastCluster = cfg.startCluster + 28'(usedClusters) - 28'd1;
  assign fatEntry    = byteIdx[IdxW-1:2];

  always_comb begin
    if (28'(fatEntry) == lastCluster) begin
      // end of chain marker
      fatWord = 32'h0FFF_FFFF;
    end else if (28'(fatEntry) >= cfg.startCluster && 28'(fatEntry) < lastCluster) begin
      fatWord = 32'(fatEntry) + 32'd1;
    end else begin
      fatWord = 32'd0;
    end
  end

  // byte source per sector kind
  always_comb begin
    case (state)
      S_DATA:  secByte = fifoByte;
      // entry only in the selected 32-byte slot
      S_DIR:   secByte = (byteIdx[IdxW-1:5] == cfg.dirSlot) ? dirEntry.raw[byteIdx[4:0]]
                                                              : 8'd0;
      // little-endian words
      S_FAT:   secByte = fatWord[8*byteIdx[1:0] +: 8];
      default: secByte = 8'd0;
    endcase
  end

  // start only while the card is ready
  assign secReq  = '{start: (state == S_REQ) && cardReady, kind: reqKind, sectorAddr: reqAddr};
  assign fifoPop = (state == S_DATA) && byteTake;
  assign status  = '{sectorsWritten: sectorCount, overLimit: overLimit};

  // ---------------------------------------------------------------------
  // main FSM
  // ---------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state        <= S_IDLE;
      reqKind      <= SEC_DATA;
      reqAddr      <= '0;
      sectorCount  <= '0;
      usedClusters <= '0;
      overLimit    <= 1'b0;
      dirPending   <= 1'b0;
      fatPending   <= 1'b0;
      byteIdx      <= '0;
    end else begin
      if ((state == S_DATA || state == S_DIR || state == S_FAT) && byteTake) begin
        byteIdx <= byteIdx + 1'b1;
      end
      case (state)
        S_IDLE: begin
          // pending updates first, directory ahead of FAT
          if (dirPending) begin
            reqKind <= SEC_DIR;
            reqAddr <= cfg.dirSector;
            state   <= S_REQ;
          end else if (fatPending) begin
            reqKind <= SEC_FAT;
            reqAddr <= cfg.fatSector;
            state   <= S_REQ;
          end else if (sectorCount >= 16'(`LOG_MAX_SECTORS)) begin
            overLimit <= 1'b1;
            state     <= S_STOP;
          end else if (dataReady) begin
            reqKind <= SEC_DATA;
            reqAddr <= cfg.fileSector + 32'(sectorCount);
            state   <= S_REQ;
          end
        end
        S_REQ: begin
          if (cardReady) begin
            byteIdx <= '0;
            case (reqKind)
              SEC_DIR: state <= S_DIR;
              SEC_FAT: state <= S_FAT;
              default: state <= S_DATA;
            endcase
          end
        end
        S_DATA: begin
          if (secDone) begin
            sectorCount <= nextCount;
            dirPending  <= dirDue;
            fatPending  <= fatDue;
            if (fatDue) usedClusters <= usedClusters + 16'd1;
            state <= S_IDLE;
          end
        end
        S_DIR: begin
          if (secDone) begin
            dirPending <= 1'b0;
            state      <= S_IDLE;
          end
        end
        S_FAT: begin
          if (secDone) begin
            fatPending <= 1'b0;
            state      <= S_IDLE;
          end
        end
        // limit reached, no more requests
        default: state <= S_STOP;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/dataLoggerTop.sv
// UART-to-SD data logger top, receiver into FIFO, sequencer to card port
// configured over wishbone before enable is set
`timescale 1ns/100ps
`default_nettype none
`include "logger_params.svh"

module dataLoggerTop (
  input  wire logic              clk,
  input  wire logic              rstn,
  input  wire logic              rx,
  // wishbone classic slave
  input  wire logic              cyc,
  input  wire logic              stb,
  input  wire logic              we,
  input  wire logic [2:0]        adr,
  input  wire logic [31:0]       datW,
  output logic      [31:0]       datR,
  output logic                   ack,
  // sector-write port
  output loggerPkg::secReqT      secReq,
  output logic      [7:0]        secByte,
  input  wire logic              cardReady,
  input  wire logic              byteTake,
  input  wire logic              secDone
);

  import loggerPkg::*;

  logic [7:0]            rxByte;
  logic                  rxValid;
  logic [7:0]            fifoByte;
  logic [`LOG_FIFO_AW:0] fifoCount;
  logic                  fifoPop;
  logCfgT                cfg;
  logStatusT             status;

  uartRx i_uartRx (
    .clk     (clk),
    .rstn    (rstn),
    .rx      (rx),
    .rxByte  (rxByte),
    .rxValid (rxValid)
  );

  // overflow drops bytes inside the FIFO
  byteFifo i_byteFifo (
    .clk      (clk),
    .rstn     (rstn),
    .push     (rxValid),
    .pushByte (rxByte),
    .pop      (fifoPop),
    .popByte  (fifoByte),
    .count    (fifoCount),
    .full     ()
  );

  loggerRegs i_loggerRegs (
    .clk    (clk),
    .rstn   (rstn),
    .cyc    (cyc),
    .stb    (stb),
    .we     (we),
    .adr    (adr),
    .datW   (datW),
    .datR   (datR),
    .ack    (ack),
    .cfg    (cfg),
    .status (status)
  );

  sectorSequencer i_sectorSequencer (
    .clk       (clk),
    .rstn      (rstn),
    .cfg       (cfg),
    .status    (status),
    .fifoByte  (fifoByte),
    .fifoCount (fifoCount),
    .fifoPop   (fifoPop),
    .secReq    (secReq),
    .secByte   (secByte),
    .cardReady (cardReady),
    .byteTake  (byteTake),
    .secDone   (secDone)
  );

endmodule

`default_nettype wire

// File: tests/tbClock.sv
// clock and reset source for the logger testbench
// reset is released just after a rising edge
`timescale 1ns/100ps
`default_nettype none

module tbClock #(
  parameter int PeriodNs    = 40,
  parameter int ResetCycles = 4
) (
  output logic clk,
  output logic rstn
);

  initial begin
    clk = 1'b0;
    forever #(PeriodNs / 2) clk = ~clk;
  end

  // low for a few rising edges
  initial begin
    rstn = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    #1;
    rstn = 1'b1;
  end

endmodule

`default_nettype wire

// File: tests/dataLogger_chk.sv
// concurrent checks on the wishbone and sector-write handshakes
// bound into the logger top level
`timescale 1ns/100ps
`default_nettype none

module dataLogger_chk (
  input wire logic              clk,
  input wire logic              rstn,
  input wire logic              cyc,
  input wire logic              stb,
  input wire logic              ack,
  input wire loggerPkg::secReqT secReq,
  input wire logic              cardReady,
  input wire logic              byteTake,
  input wire logic              secDone
);

  // sector open from its start until secDone
  logic busy;
  int   failCount = 0;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy <= 1'b0;
    end else if (secReq.start) begin
      busy <= 1'b1;
    end else if (secDone) begin
      busy <= 1'b0;
    end
  end

  // ---------------------------------------------------------------------
  // wishbone
  // ---------------------------------------------------------------------
  ackInCycle: assert property (@(posedge clk) disable iff (!rstn) ack |-> (cyc && stb))
    else begin
      $error("wishbone ack outside an active cycle");
      failCount++;
    end

  // ---------------------------------------------------------------------
  // sector-write port
  // ---------------------------------------------------------------------
  startOneCycle: assert property (@(posedge clk) disable iff (!rstn)
                                  secReq.start |=> !secReq.start)
    else begin
      $error("sector start held longer than one cycle");
      failCount++;
    end

  startWhenReady: assert property (@(posedge clk) disable iff (!rstn)
                                   secReq.start |-> cardReady)
    else begin
      $error("sector start while the card is not ready");
      failCount++;
    end

  // a new start only once the previous sector is done
  noStartWhileBusy: assert property (@(posedge clk) disable iff (!rstn)
                                     secReq.start |-> !busy)
    else begin
      $error("new sector start before secDone of the previous one");
      failCount++;
    end

endmodule

bind dataLoggerTop dataLogger_chk i_chk (.*);

`default_nettype wire

// File: tests/tbDataLogger.sv
// testbench for the UART-to-SD logger, random UART traffic and card stalls
// card model captures every sector, reference model rebuilds expected contents
`timescale 1ns/100ps
`default_nettype none
`include "logger_params.svh"

module tbDataLogger;

  import loggerPkg::*;

  localparam int          ClkNs     = 40;
  localparam int          Spc       = 4;
  localparam logic [3:0]  DirSlot   = 4'd3;
  localparam logic [31:0] FileSec   = 32'h0000_1000;
  localparam logic [31:0] DirSec    = 32'h0000_0800;
  localparam logic [31:0] FatSec    = 32'h0000_0020;
  localparam logic [27:0] StartClus = 28'd9;
  // whole file plus more than one sector past the limit
  localparam int TotalBytes  = (`LOG_MAX_SECTORS + 1) * `LOG_SECTOR_BYTES + 88;
  localparam int ExpRequests = `LOG_MAX_SECTORS + `LOG_MAX_SECTORS / `LOG_SECTORS_PER_UPDATE
                               + `LOG_MAX_SECTORS / Spc;
  // worst frame, 10 bits plus 3 idle bits
  localparam int FrameNs    = 13 * `LOG_CLKS_PER_BIT * ClkNs;
  localparam int WatchdogNs = 2 * 14 * `LOG_SECTOR_BYTES * FrameNs;

  logic        clk;
  logic        rstn;
  logic        rx;
  logic        cyc;
  logic        stb;
  logic        we;
  logic [2:0]  adr;
  logic [31:0] datW;
  logic [31:0] datR;
  logic        ack;
  secReqT      secReq;
  logic [7:0]  secByte;
  logic        cardReady;
  logic        byteTake;
  logic        secDone;

  // separate streams for UART and card, both from seed 70
  logic [31:0] sendRng = 32'd70;
  logic [31:0] cardRng = 32'd70 << 16;

  // reference model state
  logic [7:0]  sentQ [$];
  logic [7:0]  expBuf [`LOG_SECTOR_BYTES];
  logic [7:0]  gotBuf [`LOG_SECTOR_BYTES];
  int          dataCount;
  bit          dirPend;
  bit          fatPend;
  int          requests;
  bit          cardBusy;
  int          mismatches;
  int          otherErrs;

  tbClock #(.PeriodNs(ClkNs), .ResetCycles(4)) i_clock (.clk(clk), .rstn(rstn));

  dataLoggerTop i_dut (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // ends 1 ns after the n-th rising edge
  task automatic waitCycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // ---------------------------------------------------------------------
  // compare tasks
  // ---------------------------------------------------------------------
  task automatic checkWord(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      mismatches++;
      $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, exp, got);
    end
  endtask

  task automatic checkStatus(input string name, input logStatusT exp, input logStatusT got);
    if (got !== exp) begin
      mismatches++;
      $display("FAILED %s: expected sectors %0d overLimit %0b, actual sectors %0d overLimit %0b",
               name, exp.sectorsWritten, exp.overLimit, got.sectorsWritten, got.overLimit);
    end
  endtask

  // request fields, then gotBuf against expBuf
  task automatic checkSector(input string name, input secReqT exp, input secReqT got);
    int bad;
    int first;
    bad   = 0;
    first = 0;
    if (got !== exp) begin
      mismatches++;
      $display("FAILED %s request: expected kind %0d addr 0x%08h, actual kind %0d addr 0x%08h",
               name, exp.kind, exp.sectorAddr, got.kind, got.sectorAddr);
    end
    for (int i = 0; i < `LOG_SECTOR_BYTES; i++) begin
      if (gotBuf[i] !== expBuf[i]) begin
        if (bad == 0) first = i;
        bad++;
      end
    end
    if (bad != 0) begin
      mismatches++;
      $display("FAILED %s byte %0d (%0d bad): expected 0x%02h, actual 0x%02h",
               name, first, bad, expBuf[first], gotBuf[first]);
    end
  endtask

  // ---------------------------------------------------------------------
  // wishbone master, called 1 ns after a rising edge
  // ---------------------------------------------------------------------
  task automatic wbCycle(input logic write, input logic [2:0] a, input logic [31:0] d,
                         output logic [31:0] q);
    int waited;
    cyc    = 1'b1;
    stb    = 1'b1;
    we     = write;
    adr    = a;
    datW   = d;
    waited = 0;
    do begin
      waitCycles(1);
      waited++;
    end while (!ack && waited < 8);
    if (!ack) begin
      otherErrs++;
      $display("ERROR: no wishbone ack for address %0d", a);
    end
    q = datR;
    // ack taken at the next edge, then strobe drops
    waitCycles(1);
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic wbWrite(input logic [2:0] a, input logic [31:0] d);
    logic [31:0] unused;
    wbCycle(1'b1, a, d, unused);
  endtask

  task automatic wbRead(input logic [2:0] a, output logic [31:0] q);
    wbCycle(1'b0, a, 32'd0, q);
  endtask

  // 8N1 frame, lsb first
  task automatic sendFrame(input logic [7:0] b);
    rx = 1'b0;
    waitCycles(`LOG_CLKS_PER_BIT);
    for (int k = 0; k < 8; k++) begin
      rx = b[k];
      waitCycles(`LOG_CLKS_PER_BIT);
    end
    rx = 1'b1;
    waitCycles(`LOG_CLKS_PER_BIT);
  endtask

  // ---------------------------------------------------------------------
  // reference model, expected sector images
  // ---------------------------------------------------------------------
  task automatic buildDataSector();
    if (sentQ.size() < `LOG_SECTOR_BYTES) begin
      otherErrs++;
      $display("ERROR: data sector requested with only %0d bytes sent", sentQ.size());
      foreach (expBuf[i]) expBuf[i] = 8'h00;
    end else begin
      foreach (expBuf[i]) expBuf[i] = sentQ.pop_front();
    end
  endtask

  // directory entry fields per FAT layout, little-endian on disk
  task automatic buildDirSector();
    logic [87:0] nameBits;
    logic [31:0] size;
    logic [31:0] clus;
    int          base;
    nameBits = "LOG     DAT";
    size     = dataCount * `LOG_SECTOR_BYTES;
    clus     = {4'd0, StartClus};
    base     = int'(DirSlot) * 32;
    foreach (expBuf[i]) expBuf[i] = 8'h00;
    for (int i = 0; i < 11; i++) expBuf[base + i] = nameBits[87 - 8 * i -: 8];
    // archive attribute
    expBuf[base + 11] = 8'h20;
    // high cluster half at 20, low half at 26
    expBuf[base + 20] = clus[23:16];
    expBuf[base + 21] = clus[31:24];
    expBuf[base + 26] = clus[7:0];
    expBuf[base + 27] = clus[15:8];
    for (int i = 0; i < 4; i++) expBuf[base + 28 + i] = size[8 * i +: 8];
  endtask

  // chain from the start cluster, one cluster per Spc data sectors
  task automatic buildFatSector();
    int          last;
    logic [31:0] entry;
    last = int'(StartClus) + dataCount / Spc - 1;
    for (int c = 0; c < `LOG_SECTOR_BYTES / 4; c++) begin
      if (c == last) begin
        entry = 32'h0FFF_FFFF;
      end else if (c >= int'(StartClus) && c < last) begin
        entry = c + 1;
      end else begin
        entry = 32'd0;
      end
      for (int k = 0; k < 4; k++) expBuf[4 * c + k] = entry[8 * k +: 8];
    end
  endtask

  // next expected sector, directory ahead of FAT ahead of data
  task automatic checkCaptured(input secReqT got);
    secReqT exp;
    string  name;
    exp.start = 1'b1;
    if (dirPend) begin
      exp.kind       = SEC_DIR;
      exp.sectorAddr = DirSec;
      name           = $sformatf("directory after sector %0d", dataCount);
      buildDirSector();
      dirPend = 1'b0;
    end else if (fatPend) begin
      exp.kind       = SEC_FAT;
      exp.sectorAddr = FatSec;
      name           = $sformatf("FAT after sector %0d", dataCount);
      buildFatSector();
      fatPend = 1'b0;
    end else if (dataCount >= `LOG_MAX_SECTORS) begin
      otherErrs++;
      $display("ERROR: sector request at 0x%08h after the file reached its limit",
               got.sectorAddr);
      return;
    end else begin
      exp.kind       = SEC_DATA;
      exp.sectorAddr = FileSec + dataCount;
      name           = $sformatf("data sector %0d", dataCount);
      buildDataSector();
      dataCount++;
      dirPend = (dataCount % `LOG_SECTORS_PER_UPDATE) == 0;
      fatPend = (dataCount % Spc) == 0;
    end
    checkSector(name, exp, got);
  endtask

  // ---------------------------------------------------------------------
  // card model, random ready and take stalls
  // ---------------------------------------------------------------------
  initial begin : cardModel
    secReqT got;
    int     d;
    @(posedge rstn);
    waitCycles(1);
    forever begin
      cardRng   = xorshift32(cardRng);
      cardReady = (cardRng[1:0] != 2'b00);
      @(negedge clk);
      if (secReq.start) begin
        got      = secReq;
        requests++;
        cardBusy = 1'b1;
        waitCycles(1);
        cardReady = 1'b0;
        for (int i = 0; i < `LOG_SECTOR_BYTES; i++) begin
          cardRng = xorshift32(cardRng);
          d       = (cardRng[1:0] == 2'b11) ? int'(cardRng[3:2]) + 1 : 0;
          if (d != 0) begin
            byteTake = 1'b0;
            waitCycles(d);
          end
          byteTake  = 1'b1;
          // byte is stable mid-cycle
          @(negedge clk);
          gotBuf[i] = secByte;
          waitCycles(1);
        end
        byteTake = 1'b0;
        secDone  = 1'b1;
        waitCycles(1);
        secDone  = 1'b0;
        checkCaptured(got);
        cardBusy = 1'b0;
      end else begin
        waitCycles(1);
      end
    end
  end

  // ---------------------------------------------------------------------
  // main sequence
  // ---------------------------------------------------------------------
  initial begin : mainSeq
    logic [31:0] rd;
    logStatusT   expSt;
    int          total;
    rx         = 1'b1;
    cyc        = 1'b0;
    stb        = 1'b0;
    we         = 1'b0;
    adr        = 3'd0;
    datW       = 32'd0;
    cardReady  = 1'b0;
    byteTake   = 1'b0;
    secDone    = 1'b0;
    dataCount  = 0;
    dirPend    = 1'b0;
    fatPend    = 1'b0;
    requests   = 0;
    cardBusy   = 1'b0;
    mismatches = 0;
    otherErrs  = 0;
    @(posedge rstn);
    waitCycles(1);

    // configuration and readback
    wbWrite(`LOG_REG_FILESEC, FileSec);
    wbWrite(`LOG_REG_DIRSEC, DirSec);
    wbWrite(`LOG_REG_FATSEC, FatSec);
    wbWrite(`LOG_REG_CLUSTER, {DirSlot, StartClus});
    wbWrite(`LOG_REG_SPC, Spc);
    // read-only, must not change
    wbWrite(`LOG_REG_STATUS, 32'hFFFF_FFFF);
    wbRead(`LOG_REG_FILESEC, rd);
    checkWord("readback FILESEC", FileSec, rd);
    wbRead(`LOG_REG_DIRSEC, rd);
    checkWord("readback DIRSEC", DirSec, rd);
    wbRead(`LOG_REG_FATSEC, rd);
    checkWord("readback FATSEC", FatSec, rd);
    wbRead(`LOG_REG_CLUSTER, rd);
    checkWord("readback CLUSTER", {DirSlot, StartClus}, rd);
    wbRead(`LOG_REG_SPC, rd);
    checkWord("readback SPC", Spc, rd);
    wbRead(`LOG_REG_STATUS, rd);
    checkStatus("status before logging", logStatusT'(0), logStatusT'(rd[16:0]));
    wbWrite(`LOG_REG_CTRL, 32'd1);
    wbRead(`LOG_REG_CTRL, rd);
    checkWord("readback CTRL", 32'd1, rd);

    // UART traffic with random idle gaps
    for (int n = 0; n < TotalBytes; n++) begin
      sendRng = xorshift32(sendRng);
      sentQ.push_back(sendRng[7:0]);
      sendFrame(sendRng[7:0]);
      waitCycles(int'(sendRng[9:8]) * `LOG_CLKS_PER_BIT);
    end

    // all expected sectors, then room for a stray request
    while (requests < ExpRequests || cardBusy) waitCycles(1);
    waitCycles(10 * `LOG_CLKS_PER_BIT);
    if (requests != ExpRequests) begin
      otherErrs++;
      $display("ERROR: %0d sector requests seen, %0d expected", requests, ExpRequests);
    end
    expSt.sectorsWritten = 16'(`LOG_MAX_SECTORS);
    expSt.overLimit      = 1'b1;
    wbRead(`LOG_REG_STATUS, rd);
    checkStatus("status after limit", expSt, logStatusT'(rd[16:0]));

    total = mismatches + otherErrs + i_dut.i_chk.failCount;
    $display("checks done: %0d value mismatches, %0d other errors, %0d assertion failures",
             mismatches, otherErrs, i_dut.i_chk.failCount);
    if (total == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // 14 sectors of worst-case UART traffic, twice over
  initial begin : watchdog
    #(WatchdogNs);
    $display("ERROR: watchdog expired after %0d ns with %0d of %0d sector requests seen",
             WatchdogNs, requests, ExpRequests);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+verilog
verilog/loggerPkg.sv
verilog/uartRx.sv
verilog/byteFifo.sv
verilog/loggerRegs.sv
verilog/sectorSequencer.sv
verilog/dataLoggerTop.sv
tests/tbClock.sv
tests/dataLogger_chk.sv
tests/tbDataLogger.sv
